// ==== sources.f ====
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_lookup.sv
hdl/icache_way.sv
hdl/icache_hit_select.sv
hdl/icache_refill_ctrl.sv
hdl/icache_top.sv
verif/icache_properties.sv
verif/icache_tb.sv

// ==== Makefile ====
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
JOBS      ?= 4
VFLAGS    ?=

SRCS := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary --timing --assert -j $(JOBS) $(VFLAGS) \
		-f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/icache_tb.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tb import icache_pkg::*; ();

	localparam int    READ_TIMEOUT = 400; // cycles, covers a slow refill
	localparam word_t MEM_KEY      = 32'h5a3c_96e1; // memory image scramble

	logic  clk;
	logic  reset;
	logic  cpu_req;
	addr_t cpu_addr;
	logic  mem_addr_ok;
	logic  mem_data_ok;
	word_t mem_rdata;
	logic  cpu_data_ok;
	word_t cpu_rdata;
	logic  mem_req;
	addr_t mem_addr;

	logic [15:0] lfsr_state = 16'd28737;
	logic        req_seen; // mem_req observed during the current read
	addr_t       accepted [$]; // addresses taken by mem_addr_ok, current read
	bit          used_line [addr_t]; // line bases touched so far

	// reference model, valid and tag per set and way
	logic ref_valid [`ICACHE_SETS][`ICACHE_WAYS];
	tag_t ref_tag   [`ICACHE_SETS][`ICACHE_WAYS];
	int   ref_ptr   [`ICACHE_SETS]; // round robin victim

	icache_top UUT (
		.clk         (clk),
		.reset       (reset),
		.cpu_req     (cpu_req),
		.cpu_addr    (cpu_addr),
		.mem_addr_ok (mem_addr_ok),
		.mem_data_ok (mem_data_ok),
		.mem_rdata   (mem_rdata),
		.cpu_data_ok (cpu_data_ok),
		.cpu_rdata   (cpu_rdata),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns
	end

	// x^16 + x^14 + x^13 + x^11
	function automatic logic lfsr_bit();
		logic fb;
		fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			r = (r << 1) | int'(lfsr_bit()); // one step per bit
		end
		return r;
	endfunction

	// memory image: word address xor key
	function automatic word_t mem_word(input addr_t a);
		return word_t'(a >> 2) ^ MEM_KEY;
	endfunction

	function automatic void ref_clear();
		for (int s = 0; s < `ICACHE_SETS; s++) begin
			ref_ptr[s] = 0;
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_tag[s][w]   = '0;
			end
		end
	endfunction

	// returns hit, on a miss installs the line in the round robin victim
	function automatic logic ref_access(input addr_t a);
		tag_t    t;
		index_t  idx;
		offset_t off;
		{t, idx, off} = a[`ICACHE_ADDR_W-1:2]; // byte bits ignored
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (ref_valid[idx][w] && ref_tag[idx][w] == t) begin
				return 1'b1;
			end
		end
		ref_valid[idx][ref_ptr[idx]] = 1'b1;
		ref_tag[idx][ref_ptr[idx]]   = t;
		ref_ptr[idx]                 = (ref_ptr[idx] + 1) % `ICACHE_WAYS;
		return 1'b0;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) stop_run($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) stop_run($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) stop_run($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
	endtask

	// memory model, data side served before address side so the lfsr order is fixed
	initial begin : memory_model
		int    addr_wait;
		int    data_wait;
		addr_t pend_addr;
		addr_t addr_q [$]; // accepted, data still owed
		mem_addr_ok = 1'b0;
		mem_data_ok = 1'b0;
		mem_rdata   = '0;
		addr_wait   = -1;
		data_wait   = -1;
		pend_addr   = '0;
		forever begin
			@(posedge clk);
			#1;
			mem_data_ok = 1'b0;
			if (addr_q.size() > 0) begin
				if (data_wait < 0) data_wait = rand_bits(2); // 0 to 3 cycles
				if (data_wait == 0) begin
					mem_data_ok = 1'b1;
					mem_rdata   = mem_word(addr_q.pop_front()); // in order
					data_wait   = -1;
				end else begin
					data_wait--;
				end
			end
			if (mem_addr_ok) begin // taken at the edge just passed
				addr_q.push_back(pend_addr);
				accepted.push_back(pend_addr);
				mem_addr_ok = 1'b0;
			end
			if (mem_req) begin
				req_seen = 1'b1;
				if (addr_wait < 0) addr_wait = rand_bits(2);
				if (addr_wait == 0) begin
					mem_addr_ok = 1'b1;
					pend_addr   = mem_addr; // held until the accepting edge
					addr_wait   = -1;
				end else begin
					addr_wait--;
				end
			end else begin
				addr_wait = -1;
			end
		end
	end

	task automatic apply_reset();
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	// one cpu read, checked against the reference model and the memory image
	task automatic access(input addr_t a);
		logic  exp_hit;
		addr_t base;
		int    cycles;
		exp_hit = ref_access(a);
		base    = a & ~addr_t'(`ICACHE_LINE_WORDS * 4 - 1);
		used_line[base] = 1'b1;
		cycles   = 0;
		req_seen = 1'b0;
		accepted.delete();
		cpu_req  = 1'b1;
		cpu_addr = a;
		do begin
			@(posedge clk);
			#1;
			cpu_req = 1'b0; // single cycle pulse
			cycles++;
		end while (!cpu_data_ok && cycles < READ_TIMEOUT);
		if (!cpu_data_ok) stop_run($sformatf("no cpu_data_ok for read of 0x%h", a));
		check_word("cpu_rdata", cpu_rdata, mem_word(a));
		check_flag("mem_req", req_seen, !exp_hit);
		if (exp_hit && cycles != 2) begin
			stop_run($sformatf("hit on 0x%h took %0d cycles instead of 2", a, cycles));
		end
		if (!exp_hit) begin
			if (accepted.size() != `ICACHE_LINE_WORDS) begin
				stop_run($sformatf("refill of 0x%h took %0d addresses", a, accepted.size()));
			end
			foreach (accepted[i]) check_addr("mem_addr", accepted[i], base + addr_t'(4 * i));
		end
	endtask

	task automatic read_cold_line();
		access(32'h0000_1044); // tag 0x10, set 4, word 1
	endtask

	task automatic reread_same_word();
		access(32'h0000_1044);
		check_flag("mem_req", req_seen, 1'b0);
	endtask

	task automatic read_rest_of_line();
		for (int w = 0; w < `ICACHE_LINE_WORDS; w++) begin
			access(32'h0000_1040 + addr_t'(4 * w));
			check_flag("mem_req", req_seen, 1'b0);
		end
	endtask

	// three tags on set 5, two ways, so the first one is evicted
	task automatic evict_by_conflict();
		access(32'h0000_2050);
		access(32'h0000_3050);
		access(32'h0000_4050);
		access(32'h0000_2050);
		check_flag("mem_req", req_seen, 1'b1);
	endtask

	task automatic read_random_addresses();
		for (int n = 0; n < 200; n++) begin
			access(addr_t'(rand_bits(10))); // 4 tags per set, byte bits random
		end
	endtask

	task automatic reset_and_reread();
		addr_t lines [$];
		foreach (used_line[k]) lines.push_back(k);
		apply_reset();
		ref_clear();
		foreach (lines[i]) begin
			access(lines[i] + 32'h4);
			check_flag("mem_req", req_seen, 1'b1); // every line cold again
		end
	endtask

	initial begin
		reset    = 1'b1;
		cpu_req  = 1'b0;
		cpu_addr = '0;
		req_seen = 1'b0;
		ref_clear();
		apply_reset();
		read_cold_line();
		reread_same_word();
		read_rest_of_line();
		evict_by_conflict();
		read_random_addresses();
		reset_and_reread();
		$display("No errors");
		$finish;
	end

endmodule

// ==== verif/icache_properties.sv ====
`timescale 1ns/1ps

module icache_properties import icache_pkg::*; (
	input logic  clk,
	input logic  reset,
	input logic  mem_req,
	input logic  mem_addr_ok,
	input addr_t mem_addr,
	input logic  cpu_data_ok,
	input logic  miss,
	input logic  fill_en,
	input logic  busy
);

	logic missed; // a miss seen since reset

	always_ff @(posedge clk) begin
		if (reset) begin
			missed <= 1'b0;
		end else if (miss) begin
			missed <= 1'b1;
		end
	end

	// request and address held until accepted
	a_req_hold: assert property (@(posedge clk) disable iff (reset)
		mem_req && !mem_addr_ok |=> mem_req && $stable(mem_addr))
		else $error("mem_req dropped or mem_addr moved before mem_addr_ok");

	// no result while a miss is raised or its line is still being fetched
	a_hit_miss_excl: assert property (@(posedge clk) disable iff (reset)
		!(cpu_data_ok && (miss || busy)))
		else $error("cpu_data_ok together with a miss or during a refill");

	// way write only as the last step of a running refill
	a_fill_busy: assert property (@(posedge clk) disable iff (reset)
		fill_en |-> $past(busy))
		else $error("fill_en outside a refill");

	// memory stays quiet until something misses
	a_req_after_miss: assert property (@(posedge clk) disable iff (reset)
		mem_req |-> missed)
		else $error("mem_req without a preceding miss");

endmodule

bind icache_top icache_properties u_properties (
	.clk         (clk),
	.reset       (reset),
	.mem_req     (mem_req),
	.mem_addr_ok (mem_addr_ok),
	.mem_addr    (mem_addr),
	.cpu_data_ok (cpu_data_ok),
	.miss        (miss),
	.fill_en     (fill_en),
	.busy        (busy)
);

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top import icache_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  cpu_req,
	input  addr_t cpu_addr,
	input  logic  mem_addr_ok,
	input  logic  mem_data_ok,
	input  word_t mem_rdata,
	output logic  cpu_data_ok,
	output word_t cpu_rdata,
	output logic  mem_req,
	output addr_t mem_addr
);

	// lookup stage
	index_t   rd_index;
	tag_t     look_tag;
	offset_t  look_offset;
	logic     look_valid;
	way_sel_t fill_way; // victim

	// way read ports
	way_sel_t                     way_valid;
	tag_t  [`ICACHE_WAYS-1:0]     way_tag;
	line_t [`ICACHE_WAYS-1:0]     way_line;

	// refill
	logic   miss;
	logic   fill_en;
	index_t fill_index;
	tag_t   fill_tag;
	line_t  fill_line;
	logic   replay;
	logic   busy; // refill in progress

	icache_lookup u_lookup (
		.clk         (clk),
		.reset       (reset),
		.cpu_req     (cpu_req),
		.cpu_addr    (cpu_addr),
		.replay      (replay),
		.fill_en     (fill_en),
		.rd_index    (rd_index),
		.look_tag    (look_tag),
		.look_offset (look_offset),
		.look_valid  (look_valid),
		.fill_way    (fill_way)
	);

	// one way per bit of fill_way
	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		icache_way u_way (
			.clk        (clk),
			.reset      (reset),
			.rd_index   (rd_index),
			.fill_en    (fill_en),
			.fill_sel   (fill_way[w]),
			.fill_index (fill_index),
			.fill_tag   (fill_tag),
			.fill_line  (fill_line),
			.valid_out  (way_valid[w]),
			.tag_out    (way_tag[w]),
			.line_out   (way_line[w])
		);
	end

	icache_hit_select u_hit_select (
		.look_valid  (look_valid),
		.look_tag    (look_tag),
		.look_offset (look_offset),
		.way_valid   (way_valid),
		.way_tag     (way_tag),
		.way_line    (way_line),
		.cpu_data_ok (cpu_data_ok),
		.cpu_rdata   (cpu_rdata),
		.miss        (miss)
	);

	// missing line address comes straight from the held lookup fields
	icache_refill_ctrl u_refill_ctrl (
		.clk         (clk),
		.reset       (reset),
		.miss        (miss),
		.miss_tag    (look_tag),
		.miss_index  (rd_index),
		.mem_addr_ok (mem_addr_ok),
		.mem_data_ok (mem_data_ok),
		.mem_rdata   (mem_rdata),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.fill_en     (fill_en),
		.fill_index  (fill_index),
		.fill_tag    (fill_tag),
		.fill_line   (fill_line),
		.replay      (replay),
		.busy        (busy)
	);

endmodule

// ==== hdl/icache_refill_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_refill_ctrl import icache_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    miss,
	input  tag_t    miss_tag,
	input  index_t  miss_index,
	input  logic    mem_addr_ok,
	input  logic    mem_data_ok,
	input  word_t   mem_rdata,
	output logic    mem_req,
	output addr_t   mem_addr,
	output logic    fill_en,
	output index_t  fill_index,
	output tag_t    fill_tag,
	output line_t   fill_line,
	output logic    replay,
	output logic    busy
);

	typedef enum logic {
		IDLE,
		FILL
	} state_t;

	localparam offset_t LAST_WORD = offset_t'(`ICACHE_LINE_WORDS - 1);

	state_t  state;
	offset_t addr_cnt; // next word address to send
	offset_t data_cnt; // next word slot to fill
	logic    start;

	assign start = (state == IDLE) && miss;

	// main fsm, address and data sides counted apart
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= IDLE;
			mem_req  <= 1'b0;
			addr_cnt <= '0;
			data_cnt <= '0;
			fill_en  <= 1'b0;
		end else begin
			fill_en <= 1'b0; // pulse by default
			case (state)
				IDLE: begin
					if (miss) begin
						state    <= FILL;
						mem_req  <= 1'b1; // first word address goes out next cycle
						addr_cnt <= '0;
						data_cnt <= '0;
					end
				end
				FILL: begin
					// address accepted
					if (mem_req && mem_addr_ok) begin
						addr_cnt <= addr_cnt + 1'b1;
						if (addr_cnt == LAST_WORD) begin
							mem_req <= 1'b0; // all addresses out
						end
					end
					// data returned, in order
					if (mem_data_ok) begin
						data_cnt <= data_cnt + 1'b1;
						if (data_cnt == LAST_WORD) begin
							fill_en <= 1'b1; // line complete
							state   <= IDLE;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// replay trails the way write by one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			replay <= 1'b0;
		end else begin
			replay <= fill_en;
		end
	end

	// line address latched at miss
	always_ff @(posedge clk) begin
		if (start) begin
			fill_tag   <= miss_tag;
			fill_index <= miss_index;
		end
	end

	// line buffer assembly, one word per mem_data_ok
	always_ff @(posedge clk) begin
		if (state == FILL && mem_data_ok) begin
			fill_line[data_cnt] <= mem_rdata;
		end
	end

	// line base plus 4 * addr_cnt
	assign mem_addr = {fill_tag, fill_index, addr_cnt, 2'b00};

	// covers the write cycle too, fsm is already back in idle then
	assign busy = (state == FILL) | fill_en;

endmodule

// ==== hdl/icache_hit_select.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_hit_select import icache_pkg::*; (
	input  logic                        look_valid,
	input  tag_t                        look_tag,
	input  offset_t                     look_offset,
	input  way_sel_t                    way_valid,
	input  tag_t  [`ICACHE_WAYS-1:0]    way_tag,
	input  line_t [`ICACHE_WAYS-1:0]    way_line,
	output logic                        cpu_data_ok,
	output word_t                       cpu_rdata,
	output logic                        miss
);

	way_sel_t hit_vec; // at most one bit set
	line_t    hit_line;
	logic     any_hit;

	// tag compare per way
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			hit_vec[w] = way_valid[w] && (way_tag[w] == look_tag);
		end
	end

	// and-or mux over the ways, hit vector is one-hot
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (hit_vec[w]) begin
				hit_line = hit_line | way_line[w];
			end
		end
	end

	assign any_hit = |hit_vec;

	// outputs
	assign cpu_rdata   = hit_line[look_offset]; // word select
	assign cpu_data_ok = look_valid & any_hit;
	assign miss        = look_valid & ~any_hit; // single cycle, look_valid is a pulse

endmodule

// ==== hdl/icache_way.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_way import icache_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  index_t rd_index,
	input  logic   fill_en,
	input  logic   fill_sel,
	input  index_t fill_index,
	input  tag_t   fill_tag,
	input  line_t  fill_line,
	output logic   valid_out,
	output tag_t   tag_out,
	output line_t  line_out
);

	logic [`ICACHE_SETS-1:0] valid;                // one bit per set
	tag_t                    tag_mem  [`ICACHE_SETS];
	line_t                   line_mem [`ICACHE_SETS];
	logic                    wr;

	assign wr = fill_en & fill_sel; // this way is the victim

	// valid bits
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0; // whole way empty
		end else if (wr) begin
			valid[fill_index] <= 1'b1;
		end
	end

	// tag and data arrays
	always_ff @(posedge clk) begin
		if (wr) begin
			tag_mem[fill_index]  <= fill_tag;
			line_mem[fill_index] <= fill_line; // full line in one write
		end
	end

	// registered read
	// valid flag cleared with the rest of the control state
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid[rd_index];
		end
	end

	always_ff @(posedge clk) begin
		tag_out  <= tag_mem[rd_index];
		line_out <= line_mem[rd_index]; // never read in the same cycle as its fill
	end

endmodule

// ==== hdl/icache_lookup.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_lookup import icache_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     cpu_req,
	input  addr_t    cpu_addr,
	input  logic     replay,
	input  logic     fill_en,
	output index_t   rd_index,
	output tag_t     look_tag,
	output offset_t  look_offset,
	output logic     look_valid,
	output way_sel_t fill_way
);

	localparam int PTR_W    = $clog2(`ICACHE_WAYS);
	localparam int LAST_WAY = `ICACHE_WAYS - 1;

	logic             req_q; // lookup issued, way read happens next edge
	logic [PTR_W-1:0] rr_ptr [`ICACHE_SETS]; // victim way per set

	// held address, reused as is on replay
	always_ff @(posedge clk) begin
		if (cpu_req) begin
			{look_tag, rd_index, look_offset} <= cpu_addr[`ICACHE_ADDR_W-1:2]; // drop byte bits
		end
	end

	// new request or replay of the held one
	always_ff @(posedge clk) begin
		if (reset) begin
			req_q      <= 1'b0;
			look_valid <= 1'b0;
		end else begin
			req_q      <= cpu_req | replay;
			look_valid <= req_q; // lines up with the registered way read
		end
	end

	// round robin, one step per fill of the held set
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				rr_ptr[s] <= '0;
			end
		end else if (fill_en) begin
			if (rr_ptr[rd_index] == PTR_W'(LAST_WAY)) begin
				rr_ptr[rd_index] <= '0; // wrap
			end else begin
				rr_ptr[rd_index] <= rr_ptr[rd_index] + 1'b1;
			end
		end
	end

	// fill index is the held index, so its pointer names the victim
	assign fill_way = way_sel_t'(1) << rr_ptr[rd_index];

endmodule

// ==== hdl/icache_pkg.sv ====
`include "icache_consts.svh"

package icache_pkg;

	// field widths derived from the geometry macros
	localparam int OFFSET_W = $clog2(`ICACHE_LINE_WORDS); // word within line
	localparam int INDEX_W  = $clog2(`ICACHE_SETS);
	localparam int TAG_W    = `ICACHE_ADDR_W - INDEX_W - OFFSET_W - 2; // 2 byte bits dropped

	typedef logic [`ICACHE_ADDR_W-1:0] addr_t; // byte address
	typedef logic [31:0]               word_t; // one instruction

	// address fields, tag on top
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [INDEX_W-1:0]  index_t;
	typedef logic [TAG_W-1:0]    tag_t;

	// word 0 sits in the low bits
	typedef word_t [`ICACHE_LINE_WORDS-1:0] line_t;

	typedef logic [`ICACHE_WAYS-1:0] way_sel_t; // one-hot, bit per way

endpackage

// ==== hdl/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// cache geometry, shared by rtl and testbench

// associativity
`define ICACHE_WAYS 2

// sets per way, indexed by the address bits above the line offset
`define ICACHE_SETS 16

`define ICACHE_LINE_WORDS 4 // 32-bit words per line

// byte address width
// low 2 bits are byte select and ignored
`define ICACHE_ADDR_W 32

`endif
